// File: bridgeCmdPkg.sv
// Command and bus definitions
package bridgeCmdPkg;

    // Host command opcodes
    typedef enum logic [7:0] {
        opRead  = 8'h52,                  // 'R' then three address bytes
        opWrite = 8'h57,                  // 'W' then address and two data bytes
        opClear = 8'h2F                   // Drops a partial command
    } cmdOpT;

    // Parser FSM
    typedef enum logic [2:0] {
        psOpcode,                         // Waiting for opcode byte
        psAddr,                           // Collecting address bytes
        psData,                           // Collecting write data bytes
        psBus,                            // Wishbone transfer in flight
        psReply                           // Returning read word to host
    } parseStateT;

    localparam int addrBytes = 3;         // Address bytes per command
    localparam int memAddrBits = 8;       // Address bits decoded by memory

    // Wishbone classic master to slave
    typedef struct packed {
        logic        cyc;
        logic        stb;
        logic        we;                  // High for write
        logic [23:0] adr;                 // Word address
        logic [15:0] datW;
    } wbReqT;

    // Wishbone classic slave to master
    typedef struct packed {
        logic        ack;                 // Single-cycle pulse
        logic [15:0] datR;
    } wbRspT;

endpackage

// File: cmdParser.sv
// Command parser and bus master
`timescale 1ns/1ns

module cmdParser (
    input  logic                sys_clk,
    input  logic                arstN,
    input  logic [7:0]          rxData,
    input  logic                rxValid,  // One strobe per received byte
    output logic [7:0]          txData,
    output logic                txValid,
    input  logic                txReady,
    output bridgeCmdPkg::wbReqT wbReq,
    input  bridgeCmdPkg::wbRspT wbRsp,
    output logic                badCmd    // Unknown opcode pulse
);
    import bridgeCmdPkg::*;

    parseStateT  state;
    logic        isWrite;                 // Latched from opcode
    logic [1:0]  byteCnt;                 // Bytes taken in current field
    logic [23:0] addrReg;                 // Address, MSB byte first
    logic [15:0] dataReg;                 // Write data, high byte first
    logic [15:0] replyWord;               // Read result
    logic        replyHigh;               // Low byte already handed off
    logic        busCyc;                  // Drives cyc and stb together
    logic        isClear;

    assign isClear = (rxData == opClear);
    assign txData  = replyHigh ? replyWord[15:8] : replyWord[7:0];

    // Request fields stay stable while cyc is high
    always_comb begin
        wbReq.cyc  = busCyc;
        wbReq.stb  = busCyc;
        wbReq.we   = isWrite;
        wbReq.adr  = addrReg;
        wbReq.datW = dataReg;
    end

    always_ff @(posedge sys_clk or negedge arstN) begin
        if (!arstN) begin
            state     <= psOpcode;
            isWrite   <= 1'b0;
            byteCnt   <= '0;
            busCyc    <= 1'b0;
            txValid   <= 1'b0;
            replyHigh <= 1'b0;
            badCmd    <= 1'b0;
        end else begin
            badCmd <= 1'b0;
            case (state)
                psOpcode: begin
                    byteCnt <= '0;
                    if (rxValid) begin
                        case (rxData)
                            opRead: begin
                                isWrite <= 1'b0;
                                state   <= psAddr;
                            end
                            opWrite: begin
                                isWrite <= 1'b1;
                                state   <= psAddr;
                            end
                            opClear: ;                // Nothing pending here
                            default: badCmd <= 1'b1;  // Byte dropped
                        endcase
                    end
                end
                psAddr: begin
                    if (rxValid) begin
                        if (isClear) begin
                            state <= psOpcode;        // Partial command discarded
                        end else if (byteCnt == 2'(addrBytes - 1)) begin
                            byteCnt <= '0;
                            if (isWrite) begin
                                state <= psData;
                            end else begin
                                busCyc <= 1'b1;       // Request next cycle
                                state  <= psBus;
                            end
                        end else begin
                            byteCnt <= byteCnt + 1'b1;
                        end
                    end
                end
                psData: begin
                    if (rxValid) begin
                        if (isClear) begin
                            state <= psOpcode;
                        end else if (byteCnt == 2'd1) begin
                            busCyc <= 1'b1;           // Both data bytes in
                            state  <= psBus;
                        end else begin
                            byteCnt <= byteCnt + 1'b1;
                        end
                    end
                end
                psBus: begin
                    if (wbRsp.ack) begin
                        busCyc <= 1'b0;               // Drops the cycle after ack
                        if (isWrite) begin
                            state <= psOpcode;        // Write needs no reply
                        end else begin
                            txValid   <= 1'b1;
                            replyHigh <= 1'b0;
                            state     <= psReply;
                        end
                    end
                end
                psReply: begin
                    if (txReady) begin                // Handoff of current byte
                        if (!replyHigh) begin
                            replyHigh <= 1'b1;        // High byte goes next
                        end else begin
                            txValid <= 1'b0;
                            state   <= psOpcode;
                        end
                    end
                end
                default: state <= psOpcode;
            endcase
        end
    end

    // Payload registers
    always_ff @(posedge sys_clk) begin
        if (rxValid && !isClear) begin
            if (state == psAddr) addrReg <= {addrReg[15:0], rxData};
            if (state == psData) dataReg <= {dataReg[7:0], rxData};
        end
        if (state == psBus && wbRsp.ack) replyWord <= wbRsp.datR;  // Read word at ack
    end

endmodule

// File: runSim.sh
#!/bin/sh
# Build and run the bridge testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 --top-module uartMemBridgeTb -f uartMemBridgePkg.f -o simv
./obj_dir/simv > sim.log 2>&1 || true
cat sim.log

if grep -q "Done: errors found" sim.log; then
    exit 1
fi
grep -q "Done: no errors" sim.log

// File: tbClock.sv
// Testbench clock and reset
`timescale 1ns/1ns

module tbClock (
    output logic sys_clk,
    output logic arstN
);
    localparam int halfPeriod = 20;       // 40 ns period
    localparam int resetCycles = 2;

    initial begin
        sys_clk = 1'b0;
        forever #halfPeriod sys_clk = ~sys_clk;
    end

    // Reset held low for the first cycles
    initial begin
        arstN = 1'b0;
        repeat (resetCycles) @(posedge sys_clk);
        arstN <= 1'b1;                    // Released on a rising edge
    end

endmodule

// File: uartLinePkg.sv
// Serial line timing and states
package uartLinePkg;

    // System clocks per bit, small for fast simulation
    localparam int clocksPerBit = 8;      // A 27 MHz board would use 234
    localparam int halfBit = clocksPerBit / 2;  // Mid-bit sample offset

    // Counter width for one bit period
    localparam int cntBits = $clog2(clocksPerBit);

    // Receiver FSM
    typedef enum logic [1:0] {
        rxIdle,                           // Line high, waiting for start edge
        rxStart,                          // Checking start bit at mid-bit
        rxData,                           // Eight data bits, LSB first
        rxStop                            // Stop bit sample
    } rxStateT;

    // Transmitter FSM
    typedef enum logic [1:0] {
        txIdle,                           // Ready for a new byte
        txStart,                          // Driving start bit
        txData,                           // Shifting data bits
        txStop                            // Driving stop bit
    } txStateT;

endpackage

// File: uartMemBridge.sv
// Serial memory bridge top
`timescale 1ns/1ns

module uartMemBridge (
    input  logic sys_clk,
    input  logic arstN,
    input  logic rxLine,                  // Host to bridge
    output logic txLine,                  // Bridge to host
    output logic badCmd
);
    import bridgeCmdPkg::*;

    logic [7:0] rxData;
    logic       rxValid;
    logic [7:0] txData;
    logic       txValid;
    logic       txReady;
    wbReqT      wbReq;                    // Parser to memory
    wbRspT      wbRsp;                    // Memory to parser

    uartRx rxUnit (
        .sys_clk (sys_clk),
        .arstN   (arstN),
        .rxLine  (rxLine),
        .rxData  (rxData),
        .rxValid (rxValid)
    );

    cmdParser parser (
        .sys_clk (sys_clk),
        .arstN   (arstN),
        .rxData  (rxData),
        .rxValid (rxValid),
        .txData  (txData),
        .txValid (txValid),
        .txReady (txReady),
        .wbReq   (wbReq),
        .wbRsp   (wbRsp),
        .badCmd  (badCmd)
    );

    uartTx txUnit (
        .sys_clk (sys_clk),
        .arstN   (arstN),
        .txData  (txData),
        .txValid (txValid),
        .txReady (txReady),
        .txLine  (txLine)
    );

    // Far end of the bus
    wordMemory memory (
        .sys_clk (sys_clk),
        .arstN   (arstN),
        .wbReq   (wbReq),
        .wbRsp   (wbRsp)
    );

endmodule

// File: uartMemBridgePkg.f
uartLinePkg.sv
bridgeCmdPkg.sv
uartRx.sv
uartTx.sv
cmdParser.sv
wordMemory.sv
uartMemBridge.sv
tbClock.sv
uartMemBridgeTb.sv

// File: uartMemBridgeTb.sv
// Serial memory bridge testbench
`timescale 1ns/1ns

module uartMemBridgeTb;
    import uartLinePkg::*;
    import bridgeCmdPkg::*;

    localparam int frameClks = 10 * clocksPerBit;   // One 8N1 frame

    logic        sys_clk;
    logic        arstN;
    logic        rxLine;                  // Host to DUT
    logic        txLine;                  // DUT to host
    logic        badCmd;

    byte         vKind[$];                // Vector columns
    logic [23:0] vAddr[$];
    logic [15:0] vData[$];
    logic [15:0] vExp[$];
    logic [7:0]  replyQ[$];               // Bytes decoded from txLine
    int          badCount = 0;            // badCmd pulses seen
    int          failCount = 0;           // Value mismatches
    int          otherCount = 0;          // Timeouts, file and framing problems
    int          numVec = 0;

    tbClock clkGen (
        .sys_clk (sys_clk),
        .arstN   (arstN)
    );

    uartMemBridge UUT (
        .sys_clk (sys_clk),
        .arstN   (arstN),
        .rxLine  (rxLine),
        .txLine  (txLine),
        .badCmd  (badCmd)
    );

    task automatic checkByte(input string what, input logic [7:0] got, input logic [7:0] exp);
        if (got !== exp) begin
            failCount++;
            $display("FAILED %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic checkWord(input string what, input logic [15:0] got, input logic [15:0] exp);
        if (got !== exp) begin
            failCount++;
            $display("FAILED %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic checkFlag(input string what, input int got, input int exp);
        if (got != exp) begin
            failCount++;
            $display("FAILED %0t: %s is %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    // Random idle gap, then start, eight data bits LSB first, stop
    task automatic sendByte(input logic [7:0] b);
        logic [9:0] frame;
        int         i;
        frame = {1'b1, b, 1'b0};
        repeat ($urandom_range(3) * clocksPerBit) @(posedge sys_clk);
        for (i = 0; i < 10; i++) begin
            @(posedge sys_clk);
            rxLine <= frame[i];
            repeat (clocksPerBit - 1) @(posedge sys_clk);
        end
    endtask

    task automatic sendAddr(input logic [23:0] a);
        sendByte(a[23:16]);               // MSB first
        sendByte(a[15:8]);
        sendByte(a[7:0]);
    endtask

    // Wait for n reply bytes, bounded
    task automatic waitReply(input int n, output bit ok);
        int waited;
        waited = 0;
        while (replyQ.size() < n && waited < 6 * frameClks) begin
            @(posedge sys_clk);
            waited++;
        end
        ok = (replyQ.size() >= n);
    endtask

    // No reply allowed for a while
    task automatic expectQuiet(input string what);
        repeat (3 * frameClks) @(posedge sys_clk);
        if (replyQ.size() != 0) begin
            otherCount++;
            $display("Unexpected reply of %0d bytes after %s at %0t", replyQ.size(), what, $time);
            replyQ.delete();
        end
    endtask

    always @(posedge sys_clk) begin
        if (badCmd === 1'b1) badCount <= badCount + 1;   // One count per pulse
    end

    // Host side receiver, samples at mid-bit
    initial begin : txMonitor
        logic [7:0] b;
        int         i;
        wait (arstN === 1'b1);
        forever begin
            @(negedge txLine);
            repeat (halfBit) @(posedge sys_clk);
            if (txLine === 1'b0) begin
                for (i = 0; i < 8; i++) begin
                    repeat (clocksPerBit) @(posedge sys_clk);
                    b[i] = txLine;
                end
                repeat (clocksPerBit) @(posedge sys_clk);
                if (txLine === 1'b1) begin
                    replyQ.push_back(b);
                end else begin
                    otherCount++;
                    $display("Reply frame without stop bit at %0t", $time);
                end
            end
        end
    end

    initial begin : watchdog
        wait (numVec > 0);
        repeat (numVec * 40 * frameClks) @(posedge sys_clk);
        $display("Timeout: the run did not finish in time for %0d vectors", numVec);
        $display("Errors: %0d mismatches, %0d other", failCount, otherCount);
        $display("Done: errors found");
        $finish;
    end

    initial begin : mainSeq
        int          fd;
        string       line;
        int          lineNo;
        int          n;
        logic [23:0] a;
        logic [15:0] d;
        logic [15:0] e;
        logic [7:0]  lo;
        logic [7:0]  hi;
        bit          ok;
        int          expBad;
        int          i;
        rxLine = 1'b1;                    // Line idles high
        expBad = 0;
        void'($urandom(32'h2c20a4cf));
        fd = $fopen("uartMemBridge_vectors.txt", "r");
        if (fd == 0) begin
            otherCount++;
            $display("Cannot open the vector file");
        end else begin
            lineNo = 0;
            while ($fgets(line, fd) > 0) begin
                lineNo++;
                if (line.len() < 2 || line.getc(0) == "#") continue;
                n = $sscanf(line.substr(2, line.len() - 1), "%h %h %h", a, d, e);
                if (n != 3) begin
                    otherCount++;
                    $display("Vector line %0d cannot be read", lineNo);
                    continue;
                end
                vKind.push_back(line.getc(0));
                vAddr.push_back(a);
                vData.push_back(d);
                vExp.push_back(e);
            end
            $fclose(fd);
            numVec = vKind.size();        // Starts the watchdog
        end
        wait (arstN === 1'b1);
        for (i = 0; i < numVec; i++) begin
            case (vKind[i])
                "W": begin
                    sendByte(opWrite);
                    sendAddr(vAddr[i]);
                    sendByte(vData[i][15:8]);     // High byte first
                    sendByte(vData[i][7:0]);
                end
                "R": begin
                    sendByte(opRead);
                    sendAddr(vAddr[i]);
                    waitReply(2, ok);
                    if (!ok) begin
                        otherCount++;
                        $display("No reply to the read of address %h", vAddr[i]);
                        replyQ.delete();
                    end else begin
                        lo = replyQ.pop_front();  // Low byte comes first
                        hi = replyQ.pop_front();
                        checkByte("low reply byte", lo, vExp[i][7:0]);
                        checkByte("high reply byte", hi, vExp[i][15:8]);
                        checkWord("read word", {hi, lo}, vExp[i]);
                    end
                end
                "C": begin
                    sendByte(opRead);             // Partial read, two address bytes
                    sendByte(vAddr[i][23:16]);
                    sendByte(vAddr[i][15:8]);
                    sendByte(opClear);
                    expectQuiet("a cleared command");
                end
                "X": begin
                    sendByte(vData[i][7:0]);      // Unknown opcode
                    expBad++;
                    expectQuiet("a bad opcode");
                end
                default: begin
                    otherCount++;
                    $display("Vector %0d has an unknown kind", i);
                end
            endcase
            checkFlag("badCmd pulse count", badCount, expBad);
        end
        repeat (frameClks) @(posedge sys_clk);
        if (replyQ.size() != 0) begin
            otherCount++;
            $display("Stray reply bytes left at the end: %0d", replyQ.size());
        end
        $display("Errors: %0d mismatches, %0d other", failCount, otherCount);
        if (failCount == 0 && otherCount == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

// File: uartMemBridge_vectors.txt
# kind addr(hex 24 bit) data(hex) expected read word(hex)
# W write, R read and compare, C partial read then clear, X bad opcode in data low byte
W 000010 BEEF 0000
R 000010 0000 BEEF
W 000021 1234 0000
W 000042 A5C3 0000
W 0000FE 0F0F 0000
R 000042 0000 A5C3
R 0000FE 0000 0F0F
R 000021 0000 1234
R 7F0110 0000 BEEF
C 000021 0000 0000
R 000021 0000 1234
X 000000 0041 0000
R 000042 0000 A5C3
W 123421 CAFE 0000
R 000021 0000 CAFE

// File: uartRx.sv
// Serial byte receiver
`timescale 1ns/1ns

module uartRx (
    input  logic       sys_clk,
    input  logic       arstN,
    input  logic       rxLine,            // Idles high
    output logic [7:0] rxData,
    output logic       rxValid            // One strobe per good frame
);
    import uartLinePkg::*;

    logic               rxMeta;           // Synchronizer first stage
    logic               rxSync;           // Synchronized line
    rxStateT            state;
    logic [cntBits-1:0] cnt;              // Clocks within current bit
    logic [2:0]         bitIdx;           // Data bit position
    logic [7:0]         shiftReg;         // Assembled byte
    logic               lastClk;          // Bit period ends this cycle

    assign lastClk = (cnt == cntBits'(clocksPerBit - 1));
    assign rxData  = shiftReg;

    // Two-flop guard on the asynchronous line
    always_ff @(posedge sys_clk or negedge arstN) begin
        if (!arstN) begin
            rxMeta <= 1'b1;
            rxSync <= 1'b1;
        end else begin
            rxMeta <= rxLine;
            rxSync <= rxMeta;
        end
    end

    always_ff @(posedge sys_clk or negedge arstN) begin
        if (!arstN) begin
            state   <= rxIdle;
            cnt     <= '0;
            bitIdx  <= '0;
            rxValid <= 1'b0;
        end else begin
            rxValid <= 1'b0;              // Strobe lasts one cycle
            case (state)
                rxIdle: begin
                    cnt <= '0;
                    if (!rxSync) state <= rxStart;    // Possible start edge
                end
                rxStart: begin
                    if (cnt == cntBits'(halfBit - 1)) begin
                        cnt    <= '0;
                        bitIdx <= '0;
                        // Line must still be low at mid-bit
                        state  <= rxSync ? rxIdle : uartLinePkg::rxData;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                uartLinePkg::rxData: begin
                    if (lastClk) begin
                        cnt    <= '0;
                        bitIdx <= bitIdx + 1'b1;
                        if (bitIdx == 3'd7) state <= rxStop;  // Last data bit taken
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                rxStop: begin
                    if (lastClk) begin
                        rxValid <= rxSync;    // Low stop bit drops the byte
                        state   <= rxIdle;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                default: state <= rxIdle;
            endcase
        end
    end

    // Data bits arrive LSB first
    always_ff @(posedge sys_clk) begin
        if (state == uartLinePkg::rxData && lastClk) begin
            shiftReg <= {rxSync, shiftReg[7:1]};
        end
    end

endmodule

// File: uartTx.sv
// Serial byte transmitter
`timescale 1ns/1ns

module uartTx (
    input  logic       sys_clk,
    input  logic       arstN,
    input  logic [7:0] txData,
    input  logic       txValid,
    output logic       txReady,           // High only when idle
    output logic       txLine             // Idles high
);
    import uartLinePkg::*;

    txStateT            state;
    logic [cntBits-1:0] cnt;              // Clocks within current bit
    logic [2:0]         bitIdx;           // Data bits sent so far
    logic [7:0]         shiftReg;         // Data bits with ones shifted in behind
    logic               lastClk;

    assign lastClk = (cnt == cntBits'(clocksPerBit - 1));
    assign txReady = (state == txIdle);

    always_ff @(posedge sys_clk or negedge arstN) begin
        if (!arstN) begin
            state    <= txIdle;
            cnt      <= '0;
            bitIdx   <= '0;
            shiftReg <= '1;
            txLine   <= 1'b1;
        end else begin
            case (state)
                txIdle: begin
                    cnt <= '0;
                    if (txValid) begin                // Handoff cycle
                        shiftReg <= txData;
                        txLine   <= 1'b0;             // Start bit
                        state    <= txStart;
                    end
                end
                txStart: begin
                    if (lastClk) begin
                        cnt      <= '0;
                        bitIdx   <= '0;
                        txLine   <= shiftReg[0];      // First data bit
                        shiftReg <= {1'b1, shiftReg[7:1]};
                        state    <= uartLinePkg::txData;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                uartLinePkg::txData: begin
                    if (lastClk) begin
                        cnt      <= '0;
                        bitIdx   <= bitIdx + 1'b1;
                        txLine   <= shiftReg[0];      // Next bit or stop bit
                        shiftReg <= {1'b1, shiftReg[7:1]};
                        if (bitIdx == 3'd7) state <= txStop;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                txStop: begin
                    if (lastClk) state <= txIdle;     // Ready again next cycle
                    else cnt <= cnt + 1'b1;
                end
                default: state <= txIdle;
            endcase
        end
    end

endmodule

// File: wordMemory.sv
// Wishbone word memory
`timescale 1ns/1ns

module wordMemory (
    input  logic                sys_clk,
    input  logic                arstN,
    input  bridgeCmdPkg::wbReqT wbReq,
    output bridgeCmdPkg::wbRspT wbRsp
);
    import bridgeCmdPkg::*;

    logic [15:0]            mem [2**memAddrBits];  // Stands in for the PSRAM
    logic [memAddrBits-1:0] wordIdx;               // Upper address bits alias
    logic                   ackReg;
    logic [15:0]            readReg;
    logic                   access;

    assign wordIdx = wbReq.adr[memAddrBits-1:0];
    assign access  = wbReq.cyc && wbReq.stb && !ackReg;   // Once per transfer

    // Ack one cycle after strobe, held low the cycle after
    always_ff @(posedge sys_clk or negedge arstN) begin
        if (!arstN) begin
            ackReg <= 1'b0;
        end else begin
            ackReg <= access;
        end
    end

    always_ff @(posedge sys_clk) begin
        if (access && wbReq.we) mem[wordIdx] <= wbReq.datW;
        readReg <= mem[wordIdx];          // Valid by the ack cycle
    end

    always_comb begin
        wbRsp.ack  = ackReg;
        wbRsp.datR = readReg;
    end

endmodule
